// ==== files.f ====
+incdir+tests
common/exec_flags_pkg.sv
verilog/flag_alu.sv
eflags/eflags_reg.sv
verilog/wb_stage.sv
verilog/exec_flags_top.sv
tests/tb_exec_flags.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the flags-path testbench with Verilator, runs it and checks the output.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_exec_flags \
    -f files.f \
    -o tb_exec_flags

output=$(./obj_dir/tb_exec_flags)
echo "$output"

if grep -qx "All checks passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== tests/flag_model.svh ====
/*
 * Reference functions for the flags path that give results, write enables,
 * flag masks and merged flag words per operation.
 */
`ifndef FLAG_MODEL_SVH
`define FLAG_MODEL_SVH

function automatic logic [data_w-1:0] result_of(input alu_op_e op,
                                                input logic [data_w-1:0] a,
                                                input logic [data_w-1:0] b);
    logic [data_w-1:0] r;
    case (op)
        op_add:         r = a + b;
        op_sub, op_cmp: r = a - b;
        op_and:         r = a & b;
        op_or:          r = a | b;
        op_xor:         r = a ^ b;
        op_inc:         r = a + 1;
        op_dec:         r = a - 1;
        default:        r = '0;
    endcase
    return r;
endfunction

function automatic logic writes_register(input alu_op_e op);
    logic w;
    case (op)
        op_cmp, op_cld, op_std, op_popf: w = 1'b0;
        default:                         w = 1'b1;
    endcase
    return w;
endfunction

function automatic logic [flag_word_w-1:0] mask_of(input alu_op_e op);
    logic [flag_word_w-1:0] m;
    m = '0;
    case (op)
        op_add, op_sub, op_cmp, op_inc, op_dec: begin
            m[cf_bit] = 1'b1;
            m[pf_bit] = 1'b1;
            m[af_bit] = 1'b1;
            m[zf_bit] = 1'b1;
            m[sf_bit] = 1'b1;
            m[of_bit] = 1'b1;
            if (op == op_inc || op == op_dec) begin
                m[cf_bit] = 1'b0;       // Carry survives inc and dec.
            end
        end
        op_and, op_or, op_xor: begin
            m[cf_bit] = 1'b1;
            m[pf_bit] = 1'b1;
            m[zf_bit] = 1'b1;
            m[sf_bit] = 1'b1;
            m[of_bit] = 1'b1;
        end
        op_cld, op_std: m[df_bit] = 1'b1;
        op_popf:        m = '1;
        default:        m = '0;
    endcase
    return m;
endfunction

// Unmasked flag values an operation produces.
function automatic logic [flag_word_w-1:0] produced_flags(input alu_op_e op,
                                                          input logic [data_w-1:0] a,
                                                          input logic [data_w-1:0] b);
    logic [data_w-1:0]      r;
    logic [data_w-1:0]      rhs;
    logic [flag_word_w-1:0] f;
    logic [flag_word_w-1:0] legal;
    int                     ones;
    f     = '0;
    legal = '0;
    ones  = 0;
    r     = result_of(op, a, b);
    rhs   = (op == op_inc || op == op_dec) ? 32'd1 : b;
    for (int i = 0; i < 8; i++) begin
        if (r[i]) begin
            ones++;
        end
    end
    f[pf_bit] = (ones % 2 == 0);
    f[zf_bit] = (r == '0);
    f[sf_bit] = r[data_w-1];
    case (op)
        op_add, op_inc: begin
            f[cf_bit] = (r < a);                  // Wrapped past the top.
            f[af_bit] = ({1'b0, a[3:0]} + {1'b0, rhs[3:0]}) > 5'd15;
            f[of_bit] = (a[data_w-1] == rhs[data_w-1]) && (r[data_w-1] != a[data_w-1]);
        end
        op_sub, op_cmp, op_dec: begin
            f[cf_bit] = (a < rhs);                // Borrow.
            f[af_bit] = (a[3:0] < rhs[3:0]);
            f[of_bit] = (a[data_w-1] != rhs[data_w-1]) && (r[data_w-1] != a[data_w-1]);
        end
        op_std: f[df_bit] = 1'b1;
        op_popf: begin
            legal[cf_bit] = 1'b1;
            legal[pf_bit] = 1'b1;
            legal[af_bit] = 1'b1;
            legal[zf_bit] = 1'b1;
            legal[sf_bit] = 1'b1;
            legal[df_bit] = 1'b1;
            legal[of_bit] = 1'b1;
            f = b[flag_word_w-1:0] & legal;
        end
        default: ;
    endcase
    return f;
endfunction

function automatic logic [flag_word_w-1:0] merged_flags(input logic [flag_word_w-1:0] cur,
                                                        input alu_op_e op,
                                                        input logic [data_w-1:0] a,
                                                        input logic [data_w-1:0] b);
    logic [flag_word_w-1:0] m;
    m = mask_of(op);
    return (cur & ~m) | (produced_flags(op, a, b) & m);
endfunction

`endif

// ==== tests/tb_exec_flags.sv ====
/*
 * Flags path testbench with clock, reset, random stimulus,
 * model-based assertions, watchdog and reporting.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_exec_flags
    import exec_flags_pkg::*;
();

    `include "flag_model.svh"

    localparam int n_arith     = 64;
    localparam int n_logic     = 48;
    localparam int n_dir       = 24;
    localparam int n_wb        = 32;
    localparam int n_resteer   = 64;
    localparam int drain_len   = 4;
    localparam int total_len   = 4 + n_arith + n_logic + n_dir + 4 + n_wb + n_resteer
                                 + 6 * drain_len;
    localparam int timeout_ns  = (total_len + 100) * 40;

    logic    clk;
    logic    rst;
    uop_t    uop;
    logic    resteer;
    wb_t     wb;
    eflags_u spec_flags;
    eflags_u commit_flags;

    // Model state.
    logic [flag_word_w-1:0] exp_spec;
    logic [flag_word_w-1:0] exp_commit;
    logic [flag_word_w-1:0] exp_commit_next;
    logic [flag_word_w-1:0] exp_merged;
    logic                   exp_wb_valid;
    logic                   exp_wb_we;
    logic [data_w-1:0]      exp_wb_result;
    logic [flag_word_w-1:0] exp_wb_flags;

    logic [31:0] rand_state = 32'h6453fb22;
    int          error_count = 0;
    int          errors_before = 0;
    int          tests_run = 0;

    exec_flags_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .uop          (uop),
        .resteer      (resteer),
        .wb           (wb),
        .spec_flags   (spec_flags),
        .commit_flags (commit_flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic alu_op_e pick_arith(input logic [31:0] r);
        alu_op_e op;
        case (r % 32'd5)
            0:       op = op_add;
            1:       op = op_sub;
            2:       op = op_cmp;
            3:       op = op_inc;
            default: op = op_dec;
        endcase
        return op;
    endfunction

    function automatic alu_op_e pick_other(input logic [31:0] r);
        alu_op_e op;
        case (r % 32'd6)
            0:       op = op_and;
            1:       op = op_or;
            2:       op = op_xor;
            3:       op = op_cld;
            4:       op = op_std;
            default: op = op_popf;
        endcase
        return op;
    endfunction

    task automatic report_mismatch(input string name, input logic [data_w-1:0] expected,
                                   input logic [data_w-1:0] actual);
        $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic issue_uop(input alu_op_e op, input logic [data_w-1:0] a,
                             input logic [data_w-1:0] b, input logic kill);
        uop.valid = 1'b1;
        uop.op    = op;
        uop.a     = a;
        uop.b     = b;
        resteer   = kill;
        @(posedge clk);
        #5;
        uop.valid = 1'b0;
        resteer   = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        uop.valid = 1'b0;
        resteer   = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic end_test(input string name);
        idle_cycles(drain_len);
        tests_run++;
        $display("test %0d %s finished with %0d errors", tests_run, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    assign exp_commit_next = exp_wb_valid ? exp_wb_flags : exp_commit;
    assign exp_merged      = merged_flags(exp_spec, uop.op, uop.a, uop.b);

    always @(posedge clk) begin
        if (rst) begin
            exp_spec      <= '0;
            exp_commit    <= '0;
            exp_wb_valid  <= 1'b0;
            exp_wb_we     <= 1'b0;
            exp_wb_result <= '0;
            exp_wb_flags  <= '0;
        end else begin
            exp_commit <= exp_commit_next;
            if (resteer) begin
                exp_spec <= exp_commit_next;   // Recovery sees this cycle's commit.
            end else if (uop.valid) begin
                exp_spec <= exp_merged;
            end
            exp_wb_valid  <= uop.valid && !resteer;
            exp_wb_we     <= uop.valid && !resteer && writes_register(uop.op);
            exp_wb_result <= result_of(uop.op, uop.a, uop.b);
            exp_wb_flags  <= exp_merged;
        end
    end

    // Model checks on the falling edge.
    spec_match_a: assert property (@(negedge clk) disable iff (rst)
        spec_flags.raw == exp_spec)
        else report_mismatch("spec_flags", data_w'(exp_spec), data_w'(spec_flags.raw));

    commit_match_a: assert property (@(negedge clk) disable iff (rst)
        commit_flags.raw == exp_commit)
        else report_mismatch("commit_flags", data_w'(exp_commit), data_w'(commit_flags.raw));

    wb_valid_a: assert property (@(negedge clk) disable iff (rst)
        wb.valid == exp_wb_valid)
        else report_mismatch("wb.valid", data_w'(exp_wb_valid), data_w'(wb.valid));

    wb_we_a: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> (wb.we == exp_wb_we))
        else report_mismatch("wb.we", data_w'(exp_wb_we), data_w'(wb.we));

    wb_result_a: assert property (@(negedge clk) disable iff (rst)
        (wb.valid && exp_wb_we) |-> (wb.result == exp_wb_result))
        else report_mismatch("wb.result", exp_wb_result, wb.result);

    wb_flags_a: assert property (@(negedge clk) disable iff (rst)
        wb.valid |-> (wb.flags.raw == exp_wb_flags))
        else report_mismatch("wb.flags", data_w'(exp_wb_flags), data_w'(wb.flags.raw));

    resteer_sync_a: assert property (@(negedge clk) disable iff (rst)
        resteer |=> (spec_flags.raw == exp_commit))
        else report_mismatch("spec_flags", data_w'(exp_commit), data_w'(spec_flags.raw));

    initial begin
        #(timeout_ns);
        $display("Watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        rst     = 1'b1;
        uop     = '0;
        resteer = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;

        // Reset state.
        @(negedge clk);
        assert (spec_flags.raw == '0)
            else report_mismatch("spec_flags", '0, data_w'(spec_flags.raw));
        assert (commit_flags.raw == '0)
            else report_mismatch("commit_flags", '0, data_w'(commit_flags.raw));
        assert (wb.valid == 1'b0)
            else report_mismatch("wb.valid", '0, data_w'(wb.valid));
        @(posedge clk);
        #5;
        end_test("reset");

        // Back-to-back arithmetic.
        repeat (n_arith) begin
            r = next_rand();
            a = next_rand();
            issue_uop(pick_arith(r), a, (r[9:8] == 2'd0) ? a : next_rand(), 1'b0);
        end
        end_test("arithmetic");

        // Logic ops with zero and all-ones results mixed in.
        repeat (n_logic) begin
            r = next_rand();
            a = next_rand();
            case (r[9:8])
                2'd0:    issue_uop(alu_op_e'(4'(op_and + r % 32'd3)), a, ~a, 1'b0);
                2'd1:    issue_uop(op_xor, a, a, 1'b0);
                default: issue_uop(alu_op_e'(4'(op_and + r % 32'd3)), a, next_rand(), 1'b0);
            endcase
        end
        end_test("logic");

        // Direction flag and popf.
        issue_uop(op_popf, next_rand(), 32'hffff_ffff, 1'b0);
        issue_uop(op_cld, next_rand(), next_rand(), 1'b0);
        issue_uop(op_std, next_rand(), next_rand(), 1'b0);
        issue_uop(op_popf, next_rand(), 32'h0, 1'b0);
        repeat (n_dir) begin
            r = next_rand();
            issue_uop(alu_op_e'(4'(op_cld + r % 32'd3)), next_rand(), next_rand(), 1'b0);
        end
        end_test("direction and popf");

        // Writeback and commit with gaps.
        repeat (n_wb) begin
            r = next_rand();
            if (r[4]) begin
                issue_uop(r[5] ? pick_arith(r) : pick_other(r), next_rand(), next_rand(), 1'b0);
            end else begin
                idle_cycles(1);
            end
        end
        end_test("writeback and commit");

        // Resteer in a random stream.
        repeat (n_resteer) begin
            r = next_rand();
            issue_uop(r[6] ? pick_arith(r) : pick_other(r), next_rand(), next_rand(),
                      r[1:0] == 2'd0);
        end
        end_test("resteer");

        $display("%0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/exec_flags_top.sv ====
/*
 * Flags path top: ALU, EFLAGS register pair and writeback stage.
 */
`timescale 1ns/100ps
`default_nettype none

module exec_flags_top
    import exec_flags_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  uop_t    uop,
    input  logic    resteer,
    output wb_t     wb,
    output eflags_u spec_flags,
    output eflags_u commit_flags
);

    logic [data_w-1:0]      alu_result;
    logic                   alu_we;
    eflags_u                alu_flags;
    logic [flag_word_w-1:0] alu_mask;

    // Execute reads the speculative flags.
    flag_alu alu_i (
        .uop       (uop),
        .cur_flags (spec_flags),
        .result    (alu_result),
        .we        (alu_we),
        .new_flags (alu_flags),
        .flag_mask (alu_mask)
    );

    eflags_reg eflags_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (uop.valid),
        .new_flags    (alu_flags),
        .flag_mask    (alu_mask),
        .resteer      (resteer),
        .wb           (wb),
        .spec_flags   (spec_flags),
        .commit_flags (commit_flags)
    );

    // Resteer kills the uop issuing in the same cycle.
    wb_stage wb_i (
        .clk       (clk),
        .rst       (rst),
        .kill      (resteer),
        .uop_valid (uop.valid),
        .result    (alu_result),
        .we        (alu_we),
        .flags     (alu_flags),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// ==== verilog/wb_stage.sv ====
/*
 * Writeback pipeline register for result and produced flags.
 */
`timescale 1ns/100ps
`default_nettype none

module wb_stage
    import exec_flags_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              kill,
    input  logic              uop_valid,
    input  logic [data_w-1:0] result,
    input  logic              we,
    input  eflags_u           flags,
    output wb_t               wb
);

    logic live;

    assign live = uop_valid & ~kill;   // Resteer drops the issuing uop.

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
            wb.we    <= 1'b0;
        end else begin
            wb.valid <= live;
            wb.we    <= live & we;
        end
        wb.result <= result;
        wb.flags  <= flags;
    end

    // No register write may escape without a valid entry.
    we_needs_valid_a: assert property (
        @(posedge clk) disable iff (rst)
        wb.we |-> wb.valid
    ) else $error("wb_stage: we high without valid");

endmodule

`default_nettype wire

// ==== eflags/eflags_reg.sv ====
/*
 * EFLAGS register pair with the speculative copy updated at execute,
 * the committed copy updated at writeback and resteer restore.
 */
`timescale 1ns/100ps
`default_nettype none

module eflags_reg
    import exec_flags_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue,
    input  eflags_u                new_flags,
    input  logic [flag_word_w-1:0] flag_mask,
    input  logic                   resteer,
    input  wb_t                    wb,
    output eflags_u                spec_flags,
    output eflags_u                commit_flags
);

    eflags_u commit_next;
    eflags_u spec_merge;

    // Committed value after this cycle's writeback.
    always_comb begin
        if (wb.valid) begin
            commit_next = wb.flags;
        end else begin
            commit_next = commit_flags;
        end
    end

    assign spec_merge.raw = (spec_flags.raw & ~flag_mask) | (new_flags.raw & flag_mask);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_flags <= '0;
        end else begin
            commit_flags <= commit_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            spec_flags <= '0;
        end else if (resteer) begin
            spec_flags <= commit_next;        // Includes the commit in flight.
        end else if (issue) begin
            spec_flags <= spec_merge;
        end
    end

    // Recovery lines up with the committed copy one cycle later.
    resteer_sync_a: assert property (
        @(posedge clk) disable iff (rst)
        resteer |=> (spec_flags == commit_flags)
    ) else $error("eflags_reg: spec_flags %h differs from commit_flags %h after resteer",
                  spec_flags.raw, commit_flags.raw);

    // The ALU keeps flags outside the op's mask.
    mask_hold_a: assert property (
        @(posedge clk) disable iff (rst)
        issue |-> (((new_flags.raw ^ spec_flags.raw) & ~flag_mask) == '0)
    ) else $error("eflags_reg: unmasked flag changed in new_flags %h", new_flags.raw);

endmodule

`default_nettype wire

// ==== verilog/flag_alu.sv ====
/*
 * Execute-stage flag ALU: result, computed flag values, per-op flag mask
 * and the merge of the new flags over the current speculative word.
 */
`timescale 1ns/100ps
`default_nettype none

module flag_alu
    import exec_flags_pkg::*;
(
    input  uop_t                   uop,
    input  eflags_u                cur_flags,
    output logic [data_w-1:0]      result,
    output logic                   we,
    output eflags_u                new_flags,
    output logic [flag_word_w-1:0] flag_mask
);

    logic              is_sub;
    logic              is_inc_dec;
    logic              is_logic;
    logic [data_w-1:0] opnd_b;
    logic [data_w:0]   arith_ext;          // Carry or borrow on top.
    logic [data_w-1:0] arith_res;
    logic [data_w-1:0] logic_res;
    logic [data_w-1:0] alu_res;
    logic              carry;
    logic              overflow;
    logic              aux;
    eflags_u           calc_flags;

    assign is_inc_dec = (uop.op == op_inc) || (uop.op == op_dec);
    assign is_sub     = (uop.op == op_sub) || (uop.op == op_cmp) || (uop.op == op_dec);
    assign is_logic   = (uop.op == op_and) || (uop.op == op_or) || (uop.op == op_xor);

    // Inc and dec behave as add and sub of one.
    assign opnd_b = is_inc_dec ? data_w'(1) : uop.b;

    assign arith_ext = is_sub ? ({1'b0, uop.a} - {1'b0, opnd_b})
                              : ({1'b0, uop.a} + {1'b0, opnd_b});
    assign arith_res = arith_ext[data_w-1:0];
    assign carry     = arith_ext[data_w];

    // Signed overflow from the operand and result signs.
    always_comb begin
        if (is_sub) begin
            overflow = (uop.a[data_w-1] ^ opnd_b[data_w-1]) &
                       (arith_res[data_w-1] ^ uop.a[data_w-1]);
        end else begin
            overflow = ~(uop.a[data_w-1] ^ opnd_b[data_w-1]) &
                       (arith_res[data_w-1] ^ uop.a[data_w-1]);
        end
    end

    assign aux = uop.a[4] ^ opnd_b[4] ^ arith_res[4];   // Carry out of bit 3.

    always_comb begin
        case (uop.op)
            op_and:  logic_res = uop.a & uop.b;
            op_or:   logic_res = uop.a | uop.b;
            default: logic_res = uop.a ^ uop.b;
        endcase
    end

    assign alu_res = is_logic ? logic_res : arith_res;
    assign result  = alu_res;

    // Cmp and the flag-only ops leave the register file alone.
    always_comb begin
        case (uop.op)
            op_add, op_sub, op_and, op_or, op_xor, op_inc, op_dec: we = 1'b1;
            default:                                               we = 1'b0;
        endcase
    end

    always_comb begin
        calc_flags      = '0;
        calc_flags.f.zf = (alu_res == '0);
        calc_flags.f.sf = alu_res[data_w-1];
        calc_flags.f.pf = ~^alu_res[7:0];            // Even number of ones.
        calc_flags.f.cf = carry & ~is_logic;
        calc_flags.f.of = overflow & ~is_logic;
        calc_flags.f.af = aux;                       // Masked off for logic ops.
        calc_flags.f.df = (uop.op == op_std);
        if (uop.op == op_popf) begin
            calc_flags.raw = uop.b[flag_word_w-1:0] & flag_valid_mask;
        end
    end

    always_comb begin
        case (uop.op)
            op_add, op_sub, op_cmp: flag_mask = arith_mask;
            op_and, op_or, op_xor:  flag_mask = logic_mask;
            op_inc, op_dec:         flag_mask = incdec_mask;
            op_cld, op_std:         flag_mask = dir_mask;
            op_popf:                flag_mask = '1;
            default:                flag_mask = '0;
        endcase
    end

    // Untouched flags come from the current speculative word.
    assign new_flags.raw = (cur_flags.raw & ~flag_mask) | (calc_flags.raw & flag_mask);

    // Reserved bits depend on the EFLAGS register holding them at zero too.
    always_comb begin
        if (uop.valid) begin
            rsvd_zero_a: assert ((new_flags.raw & ~flag_valid_mask) == '0)
                else $error("flag_alu: reserved bits set in new_flags %h", new_flags.raw);
        end
    end

endmodule

`default_nettype wire

// ==== common/exec_flags_pkg.sv ====
/*
 * Shared types for the flags path: flag word union, ALU opcodes,
 * micro-op and writeback structs, flag positions and update masks.
 */
`default_nettype none

package exec_flags_pkg;

    localparam int flag_word_w = 18;
    localparam int data_w      = 32;

    // Architectural EFLAGS positions.
    localparam int cf_bit = 0;
    localparam int pf_bit = 2;
    localparam int af_bit = 4;
    localparam int zf_bit = 6;
    localparam int sf_bit = 7;
    localparam int df_bit = 10;
    localparam int of_bit = 11;

    localparam logic [flag_word_w-1:0] cf_m = flag_word_w'(1) << cf_bit;
    localparam logic [flag_word_w-1:0] pf_m = flag_word_w'(1) << pf_bit;
    localparam logic [flag_word_w-1:0] af_m = flag_word_w'(1) << af_bit;
    localparam logic [flag_word_w-1:0] zf_m = flag_word_w'(1) << zf_bit;
    localparam logic [flag_word_w-1:0] sf_m = flag_word_w'(1) << sf_bit;
    localparam logic [flag_word_w-1:0] df_m = flag_word_w'(1) << df_bit;
    localparam logic [flag_word_w-1:0] of_m = flag_word_w'(1) << of_bit;

    // Flags touched by each class of operation.
    localparam logic [flag_word_w-1:0] arith_mask  = cf_m | pf_m | af_m | zf_m | sf_m | of_m;
    localparam logic [flag_word_w-1:0] logic_mask  = cf_m | pf_m | zf_m | sf_m | of_m;
    localparam logic [flag_word_w-1:0] incdec_mask = arith_mask & ~cf_m;   // CF survives.
    localparam logic [flag_word_w-1:0] dir_mask    = df_m;

    // Bits that may ever be set; everything else reads as zero.
    localparam logic [flag_word_w-1:0] flag_valid_mask = arith_mask | df_m;

    // Field view, MSB first.
    typedef struct packed {
        logic [5:0] rsvd_17_12;
        logic       of;
        logic       df;
        logic [1:0] rsvd_9_8;
        logic       sf;
        logic       zf;
        logic       rsvd_5;
        logic       af;
        logic       rsvd_3;
        logic       pf;
        logic       rsvd_1;
        logic       cf;
    } eflags_fields_t;

    typedef union packed {
        logic [flag_word_w-1:0] raw;     // Popf load and reset.
        eflags_fields_t         f;       // ALU and condition view.
    } eflags_u;

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_cmp  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_inc  = 4'd6,
        op_dec  = 4'd7,
        op_cld  = 4'd8,
        op_std  = 4'd9,
        op_popf = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
    } uop_t;

    typedef struct packed {
        logic              valid;
        logic              we;       // Result goes to the register file.
        logic [data_w-1:0] result;
        eflags_u           flags;
    } wb_t;

endpackage

`default_nettype wire
